//--- sim.f
+incdir+sim
src/dmi_pkg.sv
src/jtag_tap.sv
src/dmi_cdc.sv
src/dm_regs.sv
src/debug_top.sv
sim/tb_debug_top.sv

//--- Makefile
# Verilator build and run of the debug transport testbench

TOP       ?= tb_debug_top
SEED_ARGS ?= +verilator+seed+1
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: TOP SEED_ARGS LOG VERILATOR OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sim.f
	-./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "test target: pass line found in $(LOG)"; \
	else \
		echo "test target: no pass line in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/jtag_tasks.svh
// ####################################################################
// JTAG host tasks that step the test clock and scan the IR and DR
// ####################################################################
`ifndef JTAG_TASKS_SVH
`define JTAG_TASKS_SVH
`default_nettype none

    // one test clock period, 4 system clocks low and then 4 high
    // tms and tdi move with the falling test clock, tdo is read just before the rise
    task automatic tck_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
        @(negedge i_clk);
        tck = 1'b0;
        tms = tms_v;
        tdi = tdi_v;
        repeat (3) @(negedge i_clk);
        tdo_v = tdo;
        @(negedge i_clk);
        tck = 1'b1;
        repeat (3) @(negedge i_clk);
    endtask

    // stay in run-test/idle for n test clocks
    task automatic run_idle(input int n);
        logic unused_tdo;
        repeat (n) tck_step(1'b0, 1'b0, unused_tdo);
    endtask

    // five tms highs reach test-logic-reset from any state, then park in idle
    task automatic tap_reset();
        logic unused_tdo;
        repeat (5) tck_step(1'b1, 1'b0, unused_tdo);
        tck_step(1'b0, 1'b0, unused_tdo);
    endtask

    // idle, select-dr, select-ir, capture-ir, shift 5 bits lsb first, update, idle
    task automatic shift_ir(input logic [4:0] code);
        logic unused_tdo;
        tck_step(1'b1, 1'b0, unused_tdo);
        tck_step(1'b1, 1'b0, unused_tdo);
        tck_step(1'b0, 1'b0, unused_tdo);
        tck_step(1'b0, 1'b0, unused_tdo);
        for (int i = 0; i < 5; i++) begin
            tck_step(i == 4, code[i], unused_tdo);
        end
        tck_step(1'b1, 1'b0, unused_tdo);
        tck_step(1'b0, 1'b0, unused_tdo);
    endtask

    // scans nbits lsb first and collects tdo, one spare idle clock lets the
    // request settle in the system domain before anyone looks at it
    task automatic shift_dr(input logic [40:0] din, input int nbits, output logic [40:0] dout);
        logic bit_out;
        dout = '0;
        tck_step(1'b1, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, bit_out);
        for (int i = 0; i < nbits; i++) begin
            tck_step(i == nbits - 1, din[i], bit_out);
            dout[i] = bit_out;
        end
        tck_step(1'b1, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, bit_out);
        tck_step(1'b0, 1'b0, bit_out);
    endtask

`default_nettype wire
`endif

//--- sim/tb_debug_top.sv
// ####################################################################
// testbench for the debug transport with a register model,
// concurrent checks against it and a watchdog
// ####################################################################
`default_nettype none

module tb_debug_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] TB_IDCODE = 32'h4c5a_0e1b;
    // abits 7 sits in bits 9 to 4 and version 1 in bits 3 to 0
    localparam logic [31:0] DTMCS_EXP = 32'h0000_0071;
    localparam int N_RAND = 8;
    // a test clock step is 8 system clocks, the longest scan stays below 50 steps
    localparam int TCK_STEP_NS = 320;
    localparam int SCAN_STEPS = 50;
    localparam int NUM_SCANS = 2 * N_RAND + 30;
    localparam int WATCHDOG_NS = NUM_SCANS * SCAN_STEPS * TCK_STEP_NS + 20000;

    logic        i_clk;
    logic        i_nrst;
    logic        tck;
    logic        tms;
    logic        tdi;
    logic        tdo;
    logic [31:0] data0;
    logic        haltreq;
    logic        resumereq;
    logic        ndmreset;
    logic        dmactive;

    // model of the debug registers and of what the next DMI capture returns
    logic [31:0] m_data0;
    logic [3:0]  m_ctrl;
    logic [31:0] m_rdata;
    logic [6:0]  m_last_addr;
    int          m_req_count;
    int          strobe_count;
    logic [40:0] scan_got;
    logic [40:0] scan_exp;
    logic        scan_chk;
    logic        regs_chk;
    logic [31:0] rnd;
    logic [40:0] dout;

    debug_top #(
        .IDCODE (TB_IDCODE)
    ) i_dut (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_tck       (tck),
        .i_tms       (tms),
        .i_tdi       (tdi),
        .o_tdo       (tdo),
        .o_data0     (data0),
        .o_haltreq   (haltreq),
        .o_resumereq (resumereq),
        .o_ndmreset  (ndmreset),
        .o_dmactive  (dmactive)
    );

    always #20 i_clk = ~i_clk;

    // every system strobe counts, a held request must add exactly one
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            strobe_count <= 0;
        end else if (i_dut.sys_req_valid) begin
            strobe_count <= strobe_count + 1;
        end
    end

    a_scan_out : assert property (@(posedge i_clk) disable iff (!i_nrst)
        scan_chk |-> scan_got == scan_exp)
        else report_mismatch("o_tdo scan", scan_got, scan_exp);
    a_data0 : assert property (@(posedge i_clk) disable iff (!i_nrst)
        regs_chk |-> data0 == m_data0)
        else report_mismatch("o_data0", 41'(data0), 41'(m_data0));
    a_ctrl : assert property (@(posedge i_clk) disable iff (!i_nrst)
        regs_chk |-> {haltreq, resumereq, ndmreset, dmactive} == m_ctrl)
        else report_mismatch("{o_haltreq, o_resumereq, o_ndmreset, o_dmactive}",
                             41'({haltreq, resumereq, ndmreset, dmactive}), 41'(m_ctrl));
    a_strobes : assert property (@(posedge i_clk) disable iff (!i_nrst)
        regs_chk |-> strobe_count == m_req_count)
        else report_mismatch("sys_req_valid count", 41'(strobe_count), 41'(m_req_count));

    task automatic report_mismatch(input string name, input logic [40:0] got,
                                   input logic [40:0] exp);
        $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        $display("TESTBENCH FAILED");
        $fatal(1, "check on %s failed", name);
    endtask

    // each check flag is high for one system clock, set and cleared on falling edges
    task automatic check_scan(input logic [40:0] got, input logic [40:0] exp);
        @(negedge i_clk);
        scan_got = got;
        scan_exp = exp;
        scan_chk = 1'b1;
        @(negedge i_clk);
        scan_chk = 1'b0;
    endtask

    task automatic check_outputs();
        @(negedge i_clk);
        regs_chk = 1'b1;
        @(negedge i_clk);
        regs_chk = 1'b0;
    endtask

    function automatic logic [31:0] model_read(input logic [6:0] addr);
        case (addr)
            dmi_pkg::ADDR_DATA0:     return m_data0;
            dmi_pkg::ADDR_DMCONTROL: return {m_ctrl[3:2], 28'd0, m_ctrl[1:0]};
            dmi_pkg::ADDR_DMSTATUS:  return dmi_pkg::DMSTATUS_VALUE;
            default:                 return 32'd0;
        endcase
    endfunction

    // read and write both become one request, NOP leaves everything alone
    task automatic model_request(input logic [6:0] addr, input logic [31:0] wdata,
                                 input logic [1:0] op);
        if (op == dmi_pkg::DMI_OP_WRITE) begin
            m_last_addr = addr;
            m_req_count++;
            if (addr == dmi_pkg::ADDR_DATA0) begin
                m_data0 = wdata;
            end else if (addr == dmi_pkg::ADDR_DMCONTROL) begin
                m_ctrl = {wdata[31], wdata[30], wdata[1], wdata[0]};
            end
        end else if (op == dmi_pkg::DMI_OP_READ) begin
            m_last_addr = addr;
            m_req_count++;
            m_rdata = model_read(addr);
        end
    endtask

    // the capture shows the previous request, the update issues this one
    task automatic dmi_scan(input logic [6:0] addr, input logic [31:0] wdata,
                            input logic [1:0] op);
        logic [40:0] exp;
        logic [40:0] got;
        exp = {m_last_addr, m_rdata, 2'b00};
        shift_dr({addr, wdata, op}, 41, got);
        check_scan(got, exp);
        model_request(addr, wdata, op);
        check_outputs();
    endtask

    // hardreset stays set until the next dtmcs capture releases it
    task automatic hardreset_scan();
        logic [40:0] got;
        shift_ir(dmi_pkg::IR_DTMCS);
        shift_dr(41'(32'h0002_0000), 32, got);
        check_scan(got, 41'(DTMCS_EXP));
        m_data0 = '0;
        m_ctrl = '0;
        m_rdata = '0;
        check_outputs();
        shift_dr('0, 32, got);
        check_scan(got, 41'(DTMCS_EXP));
        check_outputs();
    endtask

    initial begin
        void'($urandom(32'h5b5d420a));
        i_clk = 1'b0;
        i_nrst = 1'b0;
        tck = 1'b0;
        tms = 1'b1;
        tdi = 1'b0;
        scan_chk = 1'b0;
        regs_chk = 1'b0;
        scan_got = '0;
        scan_exp = '0;
        m_data0 = '0;
        m_ctrl = '0;
        m_rdata = '0;
        m_last_addr = '0;
        m_req_count = 0;
        repeat (5) @(negedge i_clk);
        i_nrst = 1'b1;

        // IDCODE is selected straight out of reset
        tap_reset();
        shift_dr('0, 32, dout);
        check_scan(dout, 41'(TB_IDCODE));
        check_outputs();

        // each data0 write is read back by the capture of the scan after the read
        shift_ir(dmi_pkg::IR_DMI);
        for (int k = 0; k < N_RAND; k++) begin
            rnd = $urandom();
            dmi_scan(dmi_pkg::ADDR_DATA0, rnd, dmi_pkg::DMI_OP_WRITE);
            dmi_scan(dmi_pkg::ADDR_DATA0, '0, dmi_pkg::DMI_OP_READ);
        end
        for (int k = 0; k < 4; k++) begin
            rnd = $urandom();
            dmi_scan(dmi_pkg::ADDR_DMCONTROL, rnd, dmi_pkg::DMI_OP_WRITE);
            dmi_scan(dmi_pkg::ADDR_DMCONTROL, '0, dmi_pkg::DMI_OP_READ);
        end
        dmi_scan(dmi_pkg::ADDR_DMSTATUS, '0, dmi_pkg::DMI_OP_READ);
        dmi_scan(7'h2a, '0, dmi_pkg::DMI_OP_READ);
        dmi_scan(7'h05, 32'hffff_ffff, dmi_pkg::DMI_OP_WRITE);
        dmi_scan(dmi_pkg::ADDR_DATA0, '0, dmi_pkg::DMI_OP_READ);

        // a request held over many system clocks, then a NOP with other data
        rnd = $urandom();
        dmi_scan(dmi_pkg::ADDR_DATA0, rnd, dmi_pkg::DMI_OP_WRITE);
        run_idle(24);
        check_outputs();
        dmi_scan(dmi_pkg::ADDR_DATA0, ~rnd, dmi_pkg::DMI_OP_NOP);

        // all control bits high first so the hardreset has something to clear
        dmi_scan(dmi_pkg::ADDR_DMCONTROL, 32'hc000_0003, dmi_pkg::DMI_OP_WRITE);
        hardreset_scan();

        // the hardreset also cleared the read data the next DMI capture returns
        shift_ir(dmi_pkg::IR_DMI);
        dmi_scan(dmi_pkg::ADDR_DATA0, '0, dmi_pkg::DMI_OP_NOP);

        // bypass captures a zero and then echoes tdi one clock late
        shift_ir(dmi_pkg::IR_BYPASS);
        rnd = $urandom();
        shift_dr(41'(rnd[15:0]), 17, dout);
        check_scan(dout, 41'({rnd[15:0], 1'b0}));

        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired before the scan sequence finished");
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

`include "jtag_tasks.svh"

endmodule

`default_nettype wire

//--- src/debug_top.sv
// ####################################################################
// debug transport top level, TAP to clock crossing to debug registers
// ####################################################################
`default_nettype none

module debug_top #(
    parameter logic [31:0] IDCODE = 32'h2ab4_0c1d
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_nrst,
    input  wire logic                      i_tck,
    input  wire logic                      i_tms,
    input  wire logic                      i_tdi,
    output logic                           o_tdo,
    output logic [dmi_pkg::DMI_DBITS-1:0]  o_data0,
    output logic                           o_haltreq,
    output logic                           o_resumereq,
    output logic                           o_ndmreset,
    output logic                           o_dmactive
);

    // request bundle held on the test clock
    logic                          tck_req_valid;
    logic                          tck_req_write;
    logic [dmi_pkg::DMI_ABITS-1:0] tck_req_addr;
    logic [dmi_pkg::DMI_DBITS-1:0] tck_req_data;
    logic                          tck_hardreset;

    // the same request as a strobe on the system clock
    logic                          sys_req_valid;
    logic                          sys_req_write;
    logic [dmi_pkg::DMI_ABITS-1:0] sys_req_addr;
    logic [dmi_pkg::DMI_DBITS-1:0] sys_req_data;
    logic                          sys_hardreset;

    // read data goes back as a quasi-static word
    logic [dmi_pkg::DMI_DBITS-1:0] dmi_rdata;

    jtag_tap #(
        .IDCODE (IDCODE)
    ) u_tap (
        .i_tck       (i_tck),
        .i_nrst      (i_nrst),
        .i_tms       (i_tms),
        .i_tdi       (i_tdi),
        .o_tdo       (o_tdo),
        .o_req_valid (tck_req_valid),
        .o_req_write (tck_req_write),
        .o_req_addr  (tck_req_addr),
        .o_req_data  (tck_req_data),
        .o_hardreset (tck_hardreset),
        .i_rdata     (dmi_rdata)
    );

    dmi_cdc u_cdc (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_dmi_req_valid (tck_req_valid),
        .i_dmi_req_write (tck_req_write),
        .i_dmi_req_addr  (tck_req_addr),
        .i_dmi_req_data  (tck_req_data),
        .i_dmi_hardreset (tck_hardreset),
        .o_dmi_req_valid (sys_req_valid),
        .o_dmi_req_write (sys_req_write),
        .o_dmi_req_addr  (sys_req_addr),
        .o_dmi_req_data  (sys_req_data),
        .o_dmi_hardreset (sys_hardreset)
    );

    dm_regs u_regs (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req_valid (sys_req_valid),
        .i_req_write (sys_req_write),
        .i_req_addr  (sys_req_addr),
        .i_req_data  (sys_req_data),
        .i_hardreset (sys_hardreset),
        .o_rdata     (dmi_rdata),
        .o_data0     (o_data0),
        .o_haltreq   (o_haltreq),
        .o_resumereq (o_resumereq),
        .o_ndmreset  (o_ndmreset),
        .o_dmactive  (o_dmactive)
    );

endmodule

`default_nettype wire

//--- src/dm_regs.sv
// ####################################################################
// debug register block with data0, dmcontrol and dmstatus, executing
// one DMI request per strobe in the system clock domain
// ####################################################################
`default_nettype none

module dm_regs (
    input  wire logic                           i_clk,
    input  wire logic                           i_nrst,
    input  wire logic                           i_req_valid,
    input  wire logic                           i_req_write,
    input  wire logic [dmi_pkg::DMI_ABITS-1:0]  i_req_addr,
    input  wire logic [dmi_pkg::DMI_DBITS-1:0]  i_req_data,
    input  wire logic                           i_hardreset,
    output logic [dmi_pkg::DMI_DBITS-1:0]       o_rdata,
    output logic [dmi_pkg::DMI_DBITS-1:0]       o_data0,
    output logic                                o_haltreq,
    output logic                                o_resumereq,
    output logic                                o_ndmreset,
    output logic                                o_dmactive
);

    logic [dmi_pkg::DMI_DBITS-1:0] rd_word;
    logic                          wr_en;
    logic                          rd_en;

    assign wr_en = i_req_valid && i_req_write;
    assign rd_en = i_req_valid && !i_req_write;

    // read mux, dmcontrol only keeps the four bits that are implemented
    always_comb begin
        case (i_req_addr)
            dmi_pkg::ADDR_DATA0:     rd_word = o_data0;
            dmi_pkg::ADDR_DMCONTROL: rd_word = {o_haltreq, o_resumereq, 28'd0,
                                                o_ndmreset, o_dmactive};
            dmi_pkg::ADDR_DMSTATUS:  rd_word = dmi_pkg::DMSTATUS_VALUE;
            default:                 rd_word = '0;
        endcase
    end

    // hardreset wins over any request that arrives in the same cycle
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_data0     <= '0;
            o_haltreq   <= 1'b0;
            o_resumereq <= 1'b0;
            o_ndmreset  <= 1'b0;
            o_dmactive  <= 1'b0;
            o_rdata     <= '0;
        end else if (i_hardreset) begin
            o_data0     <= '0;
            o_haltreq   <= 1'b0;
            o_resumereq <= 1'b0;
            o_ndmreset  <= 1'b0;
            o_dmactive  <= 1'b0;
            o_rdata     <= '0;
        end else begin
            if (wr_en && i_req_addr == dmi_pkg::ADDR_DATA0) begin
                o_data0 <= i_req_data;
            end
            // writes to dmstatus or unknown addresses fall through unused
            if (wr_en && i_req_addr == dmi_pkg::ADDR_DMCONTROL) begin
                o_haltreq   <= i_req_data[31];
                o_resumereq <= i_req_data[30];
                o_ndmreset  <= i_req_data[1];
                o_dmactive  <= i_req_data[0];
            end
            // read data stays put until the TAP captures it on a later scan
            if (rd_en) begin
                o_rdata <= rd_word;
            end
        end
    end

    // the TAP samples o_rdata without a handshake, so it must stay quiet
    // except right after a read or a hardreset
    a_rdata_stable : assert property (@(posedge i_clk) disable iff (!i_nrst)
        $changed(o_rdata) |-> $past(rd_en) || $past(i_hardreset));

endmodule

`default_nettype wire

//--- src/dmi_cdc.sv
// ####################################################################
// two-flop sampling of the DMI request bundle into the system clock
// domain and the once-only request strobe
// ####################################################################
`default_nettype none

module dmi_cdc (
    input  wire logic                           i_clk,
    input  wire logic                           i_nrst,
    input  wire logic                           i_dmi_req_valid,
    input  wire logic                           i_dmi_req_write,
    input  wire logic [dmi_pkg::DMI_ABITS-1:0]  i_dmi_req_addr,
    input  wire logic [dmi_pkg::DMI_DBITS-1:0]  i_dmi_req_data,
    input  wire logic                           i_dmi_hardreset,
    output logic                                o_dmi_req_valid,
    output logic                                o_dmi_req_write,
    output logic [dmi_pkg::DMI_ABITS-1:0]       o_dmi_req_addr,
    output logic [dmi_pkg::DMI_DBITS-1:0]       o_dmi_req_data,
    output logic                                o_dmi_hardreset
);

    // first and second synchronizer stages of the whole bundle
    logic [dmi_pkg::CDC_WIDTH-1:0] l1;
    logic [dmi_pkg::CDC_WIDTH-1:0] l2;
    logic                          req_accepted;
    logic                          req_fire;

    // the bundle only moves while the test side holds it stable
    // so the second stage sees a coherent word
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            l1 <= '0;
            l2 <= '0;
        end else begin
            l1 <= {i_dmi_hardreset, i_dmi_req_addr, i_dmi_req_data,
                   i_dmi_req_write, i_dmi_req_valid};
            l2 <= l1;
        end
    end

    // one strobe per held request, accepted blocks it until valid drops
    assign req_fire = l2[0] && !o_dmi_req_valid && !req_accepted;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_dmi_req_valid <= 1'b0;
            req_accepted    <= 1'b0;
            o_dmi_hardreset <= 1'b0;
        end else begin
            o_dmi_req_valid <= req_fire;
            if (req_fire) begin
                req_accepted <= 1'b1;
            end else if (!l2[0]) begin
                req_accepted <= 1'b0;
            end
            // hardreset is a level and simply follows the sampled bundle
            o_dmi_hardreset <= l2[dmi_pkg::CDC_WIDTH-1];
        end
    end

    // request fields load together with the strobe and hold until the next one
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_dmi_req_write <= 1'b0;
            o_dmi_req_data  <= '0;
            o_dmi_req_addr  <= '0;
        end else if (req_fire) begin
            o_dmi_req_write <= l2[1];
            o_dmi_req_data  <= l2[dmi_pkg::DMI_DBITS+1:2];
            o_dmi_req_addr  <= l2[dmi_pkg::CDC_WIDTH-2 -: dmi_pkg::DMI_ABITS];
        end
    end

    a_single_strobe : assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_dmi_req_valid |=> !o_dmi_req_valid);

endmodule

`default_nettype wire

//--- src/jtag_tap.sv
// ####################################################################
// JTAG test access port with IDCODE, DTMCS, DMI and BYPASS data
// registers, running on the test clock
// ####################################################################
`default_nettype none

module jtag_tap #(
    parameter logic [31:0] IDCODE = 32'h2ab4_0c1d
) (
    input  wire logic                           i_tck,
    input  wire logic                           i_nrst,
    input  wire logic                           i_tms,
    input  wire logic                           i_tdi,
    output logic                                o_tdo,
    output logic                                o_req_valid,
    output logic                                o_req_write,
    output logic [dmi_pkg::DMI_ABITS-1:0]       o_req_addr,
    output logic [dmi_pkg::DMI_DBITS-1:0]       o_req_data,
    output logic                                o_hardreset,
    input  wire logic [dmi_pkg::DMI_DBITS-1:0]  i_rdata
);

    // the DMI register is the longest one, address then data then op
    localparam int DR_W = dmi_pkg::DMI_ABITS + dmi_pkg::DMI_DBITS + 2;

    // standard TAP state encodings
    localparam logic [3:0] S_EX2DR  = 4'h0;
    localparam logic [3:0] S_EX1DR  = 4'h1;
    localparam logic [3:0] S_SHDR   = 4'h2;
    localparam logic [3:0] S_PSDR   = 4'h3;
    localparam logic [3:0] S_SELIR  = 4'h4;
    localparam logic [3:0] S_UPDR   = 4'h5;
    localparam logic [3:0] S_CAPDR  = 4'h6;
    localparam logic [3:0] S_SELDR  = 4'h7;
    localparam logic [3:0] S_EX2IR  = 4'h8;
    localparam logic [3:0] S_EX1IR  = 4'h9;
    localparam logic [3:0] S_SHIR   = 4'ha;
    localparam logic [3:0] S_PSIR   = 4'hb;
    localparam logic [3:0] S_RTI    = 4'hc;
    localparam logic [3:0] S_UPIR   = 4'hd;
    localparam logic [3:0] S_CAPIR  = 4'he;
    localparam logic [3:0] S_TLR    = 4'hf;

    // dtmcs reports idle 0, dmistat 0, abits and version 1
    localparam logic [31:0] DTMCS_VALUE = {17'd0, 3'd0, 2'd0, 6'(dmi_pkg::DMI_ABITS), 4'd1};

    logic [3:0]      state;
    logic [3:0]      state_next;
    logic [4:0]      ir;
    logic [4:0]      ir_shift;
    logic [DR_W-1:0] dr;

    // TMS walks the controller through the sixteen states
    always_comb begin
        case (state)
            S_TLR:   state_next = i_tms ? S_TLR   : S_RTI;
            S_RTI:   state_next = i_tms ? S_SELDR : S_RTI;
            S_SELDR: state_next = i_tms ? S_SELIR : S_CAPDR;
            S_CAPDR: state_next = i_tms ? S_EX1DR : S_SHDR;
            S_SHDR:  state_next = i_tms ? S_EX1DR : S_SHDR;
            S_EX1DR: state_next = i_tms ? S_UPDR  : S_PSDR;
            S_PSDR:  state_next = i_tms ? S_EX2DR : S_PSDR;
            S_EX2DR: state_next = i_tms ? S_UPDR  : S_SHDR;
            S_UPDR:  state_next = i_tms ? S_SELDR : S_RTI;
            S_SELIR: state_next = i_tms ? S_TLR   : S_CAPIR;
            S_CAPIR: state_next = i_tms ? S_EX1IR : S_SHIR;
            S_SHIR:  state_next = i_tms ? S_EX1IR : S_SHIR;
            S_EX1IR: state_next = i_tms ? S_UPIR  : S_PSIR;
            S_PSIR:  state_next = i_tms ? S_EX2IR : S_PSIR;
            S_EX2IR: state_next = i_tms ? S_UPIR  : S_SHIR;
            default: state_next = i_tms ? S_SELDR : S_RTI;
        endcase
    end

    // controller state, instruction and the request held for the system side
    always_ff @(posedge i_tck or negedge i_nrst) begin
        if (!i_nrst) begin
            state       <= S_TLR;
            ir          <= dmi_pkg::IR_IDCODE;
            o_req_valid <= 1'b0;
            o_req_write <= 1'b0;
            o_req_addr  <= '0;
            o_req_data  <= '0;
            o_hardreset <= 1'b0;
        end else begin
            state <= state_next;
            if (state == S_TLR) begin
                ir <= dmi_pkg::IR_IDCODE;
            end else if (state == S_UPIR) begin
                ir <= ir_shift;
            end
            // a new DMI capture retires the request that was held
            if (state == S_CAPDR && ir == dmi_pkg::IR_DMI) begin
                o_req_valid <= 1'b0;
            end
            if (state == S_CAPDR && ir == dmi_pkg::IR_DTMCS) begin
                o_hardreset <= 1'b0;
            end
            if (state == S_UPDR && ir == dmi_pkg::IR_DMI &&
                (dr[1:0] == dmi_pkg::DMI_OP_READ || dr[1:0] == dmi_pkg::DMI_OP_WRITE)) begin
                o_req_valid <= 1'b1;
                o_req_write <= (dr[1:0] == dmi_pkg::DMI_OP_WRITE);
                o_req_addr  <= dr[DR_W-1 -: dmi_pkg::DMI_ABITS];
                o_req_data  <= dr[dmi_pkg::DMI_DBITS+1:2];
            end
            // dtmcs bit 17 is dmihardreset
            if (state == S_UPDR && ir == dmi_pkg::IR_DTMCS && dr[17]) begin
                o_hardreset <= 1'b1;
            end
        end
    end

    // shift paths, every register shifts in at its own msb and out at bit 0
    always_ff @(posedge i_tck or negedge i_nrst) begin
        if (!i_nrst) begin
            ir_shift <= '0;
            dr       <= '0;
        end else begin
            if (state == S_CAPIR) begin
                ir_shift <= 5'b00001;
            end else if (state == S_SHIR) begin
                ir_shift <= {i_tdi, ir_shift[4:1]};
            end
            if (state == S_CAPDR) begin
                case (ir)
                    dmi_pkg::IR_IDCODE: dr <= {{(DR_W-32){1'b0}}, IDCODE};
                    dmi_pkg::IR_DTMCS:  dr <= {{(DR_W-32){1'b0}}, DTMCS_VALUE};
                    // last request address, read data and a zero status
                    dmi_pkg::IR_DMI:    dr <= {o_req_addr, i_rdata, 2'b00};
                    default:            dr <= '0;
                endcase
            end else if (state == S_SHDR) begin
                case (ir)
                    dmi_pkg::IR_DMI:    dr <= {i_tdi, dr[DR_W-1:1]};
                    dmi_pkg::IR_IDCODE,
                    dmi_pkg::IR_DTMCS:  dr <= {{(DR_W-32){1'b0}}, i_tdi, dr[31:1]};
                    default:            dr <= {{(DR_W-1){1'b0}}, i_tdi};
                endcase
            end
        end
    end

    // tdo changes on the falling test clock so the host samples a settled bit
    always_ff @(negedge i_tck or negedge i_nrst) begin
        if (!i_nrst) begin
            o_tdo <= 1'b0;
        end else if (state == S_SHIR) begin
            o_tdo <= ir_shift[0];
        end else if (state == S_SHDR) begin
            o_tdo <= dr[0];
        end else begin
            o_tdo <= 1'b0;
        end
    end

    // five tms highs must bring the controller back to test-logic-reset
    // from whatever state it was in
    a_tms_reset : assert property (@(posedge i_tck) disable iff (!i_nrst)
        i_tms && $past(i_tms) && $past(i_tms, 2) && $past(i_tms, 3) && $past(i_tms, 4)
        |=> state == S_TLR);

endmodule

`default_nettype wire

//--- src/dmi_pkg.sv
// ####################################################################
// shared widths, DMI opcodes, instruction codes and debug register
// addresses for the JTAG debug transport
// ####################################################################
`default_nettype none

package dmi_pkg;

    // DMI address and data widths as seen by the TAP and the debug module
    localparam int DMI_ABITS = 7;
    localparam int DMI_DBITS = 32;

    // op field of a DMI scan
    localparam logic [1:0] DMI_OP_NOP   = 2'd0;
    localparam logic [1:0] DMI_OP_READ  = 2'd1;
    localparam logic [1:0] DMI_OP_WRITE = 2'd2;

    // request bundle carried across the clock domains
    // hardreset, address, data, write and valid, from msb down to lsb
    localparam int CDC_WIDTH = 1 + DMI_ABITS + DMI_DBITS + 1 + 1;

    // debug module register map, only the registers that exist here
    localparam logic [DMI_ABITS-1:0] ADDR_DATA0     = 7'h04;
    localparam logic [DMI_ABITS-1:0] ADDR_DMCONTROL = 7'h10;
    localparam logic [DMI_ABITS-1:0] ADDR_DMSTATUS  = 7'h11;

    // dmstatus reads as version 2 with no hart status reported
    localparam logic [DMI_DBITS-1:0] DMSTATUS_VALUE = 32'h0000_0002;

    // JTAG instruction codes, anything else selects bypass
    localparam logic [4:0] IR_IDCODE = 5'h01;
    localparam logic [4:0] IR_DTMCS  = 5'h10;
    localparam logic [4:0] IR_DMI    = 5'h11;
    localparam logic [4:0] IR_BYPASS = 5'h1f;

endpackage

`default_nettype wire
